//--- include/boot_mem_settings.svh
`ifndef BOOT_MEM_SETTINGS_SVH
`define BOOT_MEM_SETTINGS_SVH

// bytes of storage behind the window
`define BOOT_MEM_BYTES 256

// width of a local byte offset, enough to address every byte
`define BOOT_MEM_AW 8

// MIPS reset vector, where the window sits until software moves it
`define BOOT_MEM_RESET_BASE 32'hBFC00000

`endif

//--- rtl/boot_mem_pkg.sv
`include "boot_mem_settings.svh"

package boot_mem_pkg;

    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] byte_en_t;
    typedef logic [`BOOT_MEM_AW-1:0] mem_offset_t;

    // one access into the byte array, from either the bus or the loader
    typedef struct packed {
        logic wr_en;
        logic rd_en;
        mem_offset_t offset;
        word_t data; // lane k sits in bits 8k+7:8k
        byte_en_t be;
    } ram_req_t;

    typedef enum logic [1:0] {
        load_idle,
        load_write,
        load_done
    } loader_state_t;

endpackage

//--- rtl/mem_window_regs.sv
`timescale 1ns/1ps

`include "boot_mem_settings.svh"

module mem_window_regs import boot_mem_pkg::*; (
    input logic clk,
    input logic reset,
    input logic cfg_write,
    input logic cfg_sel,
    input word_t cfg_wdata,
    output word_t cfg_rdata,
    input logic fault_set,
    input logic fault_clear,
    output logic window_fault,
    output bus_addr_t window_base,
    output mem_offset_t load_base
);

    // select 0 is the window base, select 1 the load start
    always_ff @(posedge clk) begin
        if (reset) begin
            window_base <= `BOOT_MEM_RESET_BASE;
            load_base <= '0;
        end else if (cfg_write) begin
            if (cfg_sel) begin
                load_base <= mem_offset_t'(cfg_wdata); // upper bits are dropped
            end else begin
                window_base <= cfg_wdata;
            end
        end
    end

    // sticky until software clears it, a clear wins over a new fault
    always_ff @(posedge clk) begin
        if (reset) begin
            window_fault <= 1'b0;
        end else if (fault_clear) begin
            window_fault <= 1'b0;
        end else if (fault_set) begin
            window_fault <= 1'b1;
        end
    end

    always_comb begin
        if (cfg_sel) begin
            cfg_rdata = word_t'(load_base);
        end else begin
            cfg_rdata = window_base;
        end
    end

endmodule

//--- rtl/byte_lane_ram.sv
`timescale 1ns/1ps

`include "boot_mem_settings.svh"

module byte_lane_ram import boot_mem_pkg::*; (
    input logic clk,
    input logic reset,
    input ram_req_t req,
    output word_t rd_word
);

    logic [7:0] mem [0:`BOOT_MEM_BYTES-1];
    mem_offset_t lane_addr [0:3];

    // byte k of the word lives at offset + k, wrapping inside the array
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            lane_addr[k] = req.offset + mem_offset_t'(k);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `BOOT_MEM_BYTES; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (req.wr_en) begin
            for (int k = 0; k < 4; k++) begin
                if (req.be[k]) begin
                    mem[lane_addr[k]] <= req.data[8*k +: 8];
                end
            end
        end
    end

    // read data is registered, so it shows up the cycle after the request
    always_ff @(posedge clk) begin
        if (req.rd_en) begin
            for (int k = 0; k < 4; k++) begin
                rd_word[8*k +: 8] <= mem[lane_addr[k]]; // lowest address in bits 7:0
            end
        end
    end

endmodule

//--- rtl/inst_loader.sv
`timescale 1ns/1ps

`include "boot_mem_settings.svh"

module inst_loader import boot_mem_pkg::*; (
    input logic clk,
    input logic reset,
    input logic load_start,
    input mem_offset_t load_base,
    input logic inst_valid,
    input word_t inst_word,
    output logic inst_ready,
    output ram_req_t loader_req,
    output logic loader_req_valid,
    output logic [7:0] load_count
);

    loader_state_t state;
    loader_state_t state_next;
    mem_offset_t ptr;
    logic [`BOOT_MEM_AW:0] ptr_sum;
    word_t word_q;

    assign ptr_sum = {1'b0, ptr} + 4; // the top bit flags a wrap past the last word

    always_comb begin
        state_next = state;
        case (state)
            load_idle: if (inst_valid && inst_ready) state_next = load_write;
            load_write: state_next = ptr_sum[`BOOT_MEM_AW] ? load_done : load_idle;
            default: state_next = load_done;
        endcase
        if (load_start && state_next == load_done) begin
            state_next = load_idle; // a restart reopens the input
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= load_idle;
            inst_ready <= 1'b0;
            ptr <= '0;
            load_count <= '0;
        end else begin
            state <= state_next;
            inst_ready <= (state_next == load_idle); // low while a word is being written
            if (load_start) begin
                ptr <= load_base;
                load_count <= '0;
            end else if (state == load_write) begin
                ptr <= ptr_sum[`BOOT_MEM_AW-1:0];
                load_count <= load_count + 8'd1;
            end
        end
    end

    // big-endian store: bits 31:24 land at the pointer itself
    always_ff @(posedge clk) begin
        if (inst_valid && inst_ready) begin
            word_q <= {inst_word[7:0], inst_word[15:8], inst_word[23:16], inst_word[31:24]};
        end
    end

    assign loader_req_valid = (state == load_write);
    assign loader_req = '{
        wr_en: (state == load_write),
        rd_en: 1'b0,
        offset: ptr,
        data: word_q,
        be: 4'hF
    };

endmodule

//--- rtl/bus_slave_port.sv
`timescale 1ns/1ps

`include "boot_mem_settings.svh"

module bus_slave_port import boot_mem_pkg::*; (
    input logic clk,
    input logic reset,
    input bus_addr_t address,
    input logic read,
    input logic write,
    input word_t writedata,
    input byte_en_t byteenable,
    output logic waitrequest,
    output word_t readdata,
    output logic readdatavalid,
    input bus_addr_t window_base,
    output logic fault_set,
    input ram_req_t loader_req,
    input logic loader_req_valid,
    output ram_req_t ram_req,
    input word_t rd_word
);

    // the last word must fit completely, so the final three offsets are outside
    localparam bus_addr_t window_limit = `BOOT_MEM_BYTES - 3;

    bus_addr_t offset_full;
    logic in_window;
    logic accept_rd;
    logic accept_wr;
    logic rd_pending;
    logic rd_hit;

    assign offset_full = address - window_base; // an address below the base wraps high
    assign in_window = (offset_full < window_limit);

    // the loader owns the RAM port in its write cycle, the bus waits one cycle
    assign waitrequest = loader_req_valid;
    assign accept_rd = read && !waitrequest;
    assign accept_wr = write && !waitrequest;
    assign fault_set = (accept_rd || accept_wr) && !in_window;

    always_comb begin
        if (loader_req_valid) begin
            ram_req = loader_req;
        end else begin
            ram_req.wr_en = accept_wr && in_window;
            ram_req.rd_en = accept_rd && in_window;
            ram_req.offset = mem_offset_t'(offset_full);
            ram_req.data = writedata;
            ram_req.be = byteenable;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pending <= 1'b0;
            rd_hit <= 1'b0;
        end else begin
            rd_pending <= accept_rd;
            rd_hit <= accept_rd && in_window;
        end
    end

    assign readdatavalid = rd_pending;
    assign readdata = rd_hit ? rd_word : '0; // a read outside the window returns zero

endmodule

//--- rtl/boot_mem_top.sv
`timescale 1ns/1ps

module boot_mem_top import boot_mem_pkg::*; (
    input logic clk,
    input logic reset,
    input bus_addr_t address,
    input logic read,
    input logic write,
    input word_t writedata,
    input byte_en_t byteenable,
    output logic waitrequest,
    output word_t readdata,
    output logic readdatavalid,
    input logic inst_valid,
    input word_t inst_word,
    output logic inst_ready,
    input logic load_start,
    output logic [7:0] load_count,
    input logic cfg_write,
    input logic cfg_sel,
    input word_t cfg_wdata,
    output word_t cfg_rdata,
    input logic fault_clear,
    output logic window_fault
);

    bus_addr_t window_base;
    mem_offset_t load_base;
    logic fault_set;
    ram_req_t loader_req;
    logic loader_req_valid;
    ram_req_t ram_req;
    word_t rd_word;

    mem_window_regs i_regs (
        .clk(clk), .reset(reset),
        .cfg_write(cfg_write), .cfg_sel(cfg_sel), .cfg_wdata(cfg_wdata),
        .cfg_rdata(cfg_rdata),
        .fault_set(fault_set), .fault_clear(fault_clear), .window_fault(window_fault),
        .window_base(window_base), .load_base(load_base)
    );

    inst_loader i_loader (
        .clk(clk), .reset(reset),
        .load_start(load_start), .load_base(load_base),
        .inst_valid(inst_valid), .inst_word(inst_word), .inst_ready(inst_ready),
        .loader_req(loader_req), .loader_req_valid(loader_req_valid),
        .load_count(load_count)
    );

    bus_slave_port i_port (
        .clk(clk), .reset(reset),
        .address(address), .read(read), .write(write),
        .writedata(writedata), .byteenable(byteenable),
        .waitrequest(waitrequest), .readdata(readdata), .readdatavalid(readdatavalid),
        .window_base(window_base), .fault_set(fault_set),
        .loader_req(loader_req), .loader_req_valid(loader_req_valid),
        .ram_req(ram_req), .rd_word(rd_word)
    );

    byte_lane_ram i_ram (
        .clk(clk), .reset(reset),
        .req(ram_req), .rd_word(rd_word)
    );

endmodule

//--- verification/boot_mem_tb.sv
`timescale 1ns/1ps

`include "boot_mem_settings.svh"

module boot_mem_tb import boot_mem_pkg::*; ();

    localparam int clk_period = 40;
    localparam int win_span = `BOOT_MEM_BYTES - 3;
    // rough cycle counts of reset and the six tests
    localparam int budget_cycles = 5 + 15 + 105 + 45 + 15 + 20 + 105;

    logic clk;
    logic reset;
    bus_addr_t address;
    logic read;
    logic write;
    word_t writedata;
    byte_en_t byteenable;
    logic waitrequest;
    word_t readdata;
    logic readdatavalid;
    logic inst_valid;
    word_t inst_word;
    logic inst_ready;
    logic load_start;
    logic [7:0] load_count;
    logic cfg_write;
    logic cfg_sel;
    word_t cfg_wdata;
    word_t cfg_rdata;
    logic fault_clear;
    logic window_fault;

    logic [7:0] ref_mem [0:`BOOT_MEM_BYTES-1]; // reference image of the RAM
    bus_addr_t ref_base;
    mem_offset_t ref_load_base;
    mem_offset_t ref_ptr;
    logic [31:0] lfsr;
    word_t exp_q [$];
    word_t exp_word;
    int err_count;
    int test_err_start;
    int tests_failed;
    int reads_compared;
    int wait_cycles;
    int words_sent;

    boot_mem_top i_dut (
        .clk(clk), .reset(reset),
        .address(address), .read(read), .write(write),
        .writedata(writedata), .byteenable(byteenable),
        .waitrequest(waitrequest), .readdata(readdata), .readdatavalid(readdatavalid),
        .inst_valid(inst_valid), .inst_word(inst_word), .inst_ready(inst_ready),
        .load_start(load_start), .load_count(load_count),
        .cfg_write(cfg_write), .cfg_sel(cfg_sel), .cfg_wdata(cfg_wdata),
        .cfg_rdata(cfg_rdata), .fault_clear(fault_clear), .window_fault(window_fault)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // taps 32, 22, 2 and 1, stepped once for every bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    // the expected bus read has the lowest address in bits 7:0 and is zero outside the window
    function automatic word_t ref_read(input bus_addr_t addr);
        bus_addr_t off;
        word_t w;
        off = addr - ref_base;
        w = '0;
        if (off < win_span) begin
            for (int k = 0; k < 4; k++) begin
                w[8*k +: 8] = ref_mem[off + k];
            end
        end
        return w;
    endfunction

    function automatic void ref_write(input bus_addr_t addr, input word_t data,
                                      input byte_en_t be);
        bus_addr_t off;
        off = addr - ref_base;
        if (off < win_span) begin
            for (int k = 0; k < 4; k++) begin
                if (be[k]) begin
                    ref_mem[off + k] = data[8*k +: 8];
                end
            end
        end
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERROR at %0t: %s expected %h got %h", $time, sig, exp, act);
        err_count++;
    endtask

    task automatic bus_read(input bus_addr_t addr);
        address = addr;
        read = 1'b1;
        while (waitrequest) begin
            wait_cycles++;
            @(negedge clk);
        end
        exp_q.push_back(ref_read(addr)); // accepted on the coming rising edge
        @(negedge clk);
        read = 1'b0;
        // read data comes back in the cycle right after acceptance
        if (readdatavalid !== 1'b1) report_mismatch("readdatavalid", 1, readdatavalid);
    endtask

    task automatic bus_write(input bus_addr_t addr, input word_t data, input byte_en_t be);
        address = addr;
        writedata = data;
        byteenable = be;
        write = 1'b1;
        while (waitrequest) @(negedge clk);
        ref_write(addr, data, be);
        @(negedge clk);
        write = 1'b0;
    endtask

    // bits 31:24 go to the pointer itself, so the word is stored big-endian
    task automatic load_word(input word_t w, input logic [1:0] gap);
        inst_word = w;
        inst_valid = 1'b1;
        while (!inst_ready) @(negedge clk);
        for (int k = 0; k < 4; k++) begin
            ref_mem[mem_offset_t'(ref_ptr + k)] = w[31-8*k -: 8];
        end
        ref_ptr = ref_ptr + 8'd4;
        words_sent++;
        @(negedge clk);
        inst_valid = 1'b0;
        // the loader holds the RAM port in the cycle after the handshake
        if (inst_ready !== 1'b0) report_mismatch("inst_ready", 0, inst_ready);
        if (waitrequest !== 1'b1) report_mismatch("waitrequest", 1, waitrequest);
        repeat (gap) @(negedge clk);
    endtask

    task automatic cfg_write_reg(input logic sel, input word_t data);
        cfg_sel = sel;
        cfg_wdata = data;
        cfg_write = 1'b1;
        @(negedge clk);
        cfg_write = 1'b0;
    endtask

    task automatic pulse_load_start();
        load_start = 1'b1;
        @(negedge clk);
        load_start = 1'b0;
        ref_ptr = ref_load_base;
        words_sent = 0;
    endtask

    task automatic pulse_fault_clear();
        fault_clear = 1'b1;
        @(negedge clk);
        fault_clear = 1'b0;
    endtask

    task automatic end_test(input string name);
        while (exp_q.size() != 0) @(negedge clk);
        if (err_count == test_err_start) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed with %0d errors", name, err_count - test_err_start);
            tests_failed++;
        end
        test_err_start = err_count;
    endtask

    // every returned word is checked against the value queued when its read went out
    always @(negedge clk) begin
        if (readdatavalid) begin
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t: readdatavalid high with no read outstanding", $time);
                err_count++;
            end else begin
                exp_word = exp_q.pop_front();
                reads_compared++;
                if (readdata !== exp_word) report_mismatch("readdata", exp_word, readdata);
            end
        end
    end

    initial begin
        #(2 * budget_cycles * clk_period);
        $display("timeout: the tests did not finish within %0d ns",
                 2 * budget_cycles * clk_period);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        bus_addr_t a;
        word_t d;
        byte_en_t be;
        word_t load_data [16];
        logic [1:0] load_gap [16];
        bus_addr_t rd_addr [24];
        lfsr = 32'h33ac;
        reset = 1'b1;
        address = '0;
        read = 1'b0;
        write = 1'b0;
        writedata = '0;
        byteenable = '0;
        inst_valid = 1'b0;
        inst_word = '0;
        load_start = 1'b0;
        cfg_write = 1'b0;
        cfg_sel = 1'b0;
        cfg_wdata = '0;
        fault_clear = 1'b0;
        for (int i = 0; i < `BOOT_MEM_BYTES; i++) ref_mem[i] = 8'h00;
        ref_base = `BOOT_MEM_RESET_BASE;
        ref_load_base = '0;
        ref_ptr = '0;
        err_count = 0;
        test_err_start = 0;
        tests_failed = 0;
        reads_compared = 0;
        wait_cycles = 0;
        words_sent = 0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        for (int i = 0; i < 8; i++) bus_read(ref_base + take_bits(8) % win_span);
        if (window_fault !== 1'b0) report_mismatch("window_fault", 0, window_fault);
        end_test("after reset");

        pulse_load_start();
        for (int i = 0; i < 16; i++) begin
            d = take_bits(32);
            load_word(d, take_bits(2));
        end
        for (int i = 0; i < 16; i++) bus_read(ref_base + 4 * i);
        if (load_count !== 8'(words_sent)) report_mismatch("load_count", words_sent, load_count);
        end_test("loader");

        for (int i = 0; i < 20; i++) begin
            a = ref_base + take_bits(8) % win_span;
            d = take_bits(32);
            be = take_bits(4);
            bus_write(a, d, be);
            bus_read(a);
        end
        end_test("bus writes");

        bus_read(ref_base + win_span); // first offset past the window
        if (window_fault !== 1'b1) report_mismatch("window_fault", 1, window_fault);
        pulse_fault_clear();
        if (window_fault !== 1'b0) report_mismatch("window_fault", 0, window_fault);
        bus_write(ref_base + 256, take_bits(32), 4'hF); // would alias offset 0
        bus_write(ref_base - 1, take_bits(32), 4'hF);
        if (window_fault !== 1'b1) report_mismatch("window_fault", 1, window_fault);
        bus_read(ref_base);
        bus_read(ref_base + 252);
        pulse_fault_clear();
        if (window_fault !== 1'b0) report_mismatch("window_fault", 0, window_fault);
        end_test("window fault");

        cfg_write_reg(1'b0, 32'h0000_1000);
        if (cfg_rdata !== 32'h0000_1000) report_mismatch("cfg_rdata", 32'h1000, cfg_rdata);
        ref_base = 32'h0000_1000;
        for (int i = 0; i < 8; i++) bus_read(ref_base + take_bits(8) % win_span);
        bus_read(`BOOT_MEM_RESET_BASE);
        if (window_fault !== 1'b1) report_mismatch("window_fault", 1, window_fault);
        pulse_fault_clear();
        cfg_write_reg(1'b1, 32'h0000_0080);
        if (cfg_rdata !== 32'h0000_0080) report_mismatch("cfg_rdata", 32'h80, cfg_rdata);
        ref_load_base = 8'h80;
        end_test("window move");

        // loader fills 0x80 and up while the bus reads below 0x80
        for (int i = 0; i < 16; i++) begin
            load_data[i] = take_bits(32);
            load_gap[i] = take_bits(2);
        end
        for (int j = 0; j < 24; j++) rd_addr[j] = ref_base + take_bits(7) % 125;
        pulse_load_start();
        wait_cycles = 0;
        fork
            for (int i = 0; i < 16; i++) load_word(load_data[i], load_gap[i]);
            for (int j = 0; j < 24; j++) bus_read(rd_addr[j]);
        join
        if (wait_cycles == 0) begin
            $display("ERROR at %0t: no bus read was held by waitrequest during the load", $time);
            err_count++;
        end
        for (int i = 0; i < 16; i++) bus_read(ref_base + 32'h80 + 4 * i);
        if (load_count !== 8'(words_sent)) report_mismatch("load_count", words_sent, load_count);
        end_test("reads during load");

        $display("tests run 6, tests failed %0d, reads compared %0d, errors %0d",
                 tests_failed, reads_compared, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+include
rtl/boot_mem_pkg.sv
rtl/mem_window_regs.sv
rtl/byte_lane_ram.sv
rtl/inst_loader.sv
rtl/bus_slave_port.sv
rtl/boot_mem_top.sv
verification/boot_mem_tb.sv
